// File: src/msx_io_params.svh
`ifndef MSX_IO_PARAMS_SVH
`define MSX_IO_PARAMS_SVH

// PSG ports A0 address latch, A1 data write, A2 data read
`define MSX_PSG_BASE 8'hA0

// PPI ports A8 port A, A9 port B, AA port C, AB control
`define MSX_PPI_BASE 8'hA8

// Keyboard matrix rows, 8 keys per row
`define MSX_KB_ROWS 11

// Tone period width of one PSG channel
`define MSX_TONE_W 12

`endif

// File: src/msx_bus_pkg.sv
package msx_bus_pkg;

   // Device selected by an I/O port address
   typedef enum logic [1:0] {
      DEV_NONE = 2'd0,
      DEV_PPI  = 2'd1,
      DEV_PSG  = 2'd2
   } io_dev_t;

   // Z80 I/O port address, low byte only
   typedef logic [7:0] io_addr_t;

   // Data byte on the CPU bus
   typedef logic [7:0] io_data_t;

   // Register offset inside a device window
   typedef logic [1:0] io_ofs_t;

endpackage

// File: src/msx_audio_pkg.sv
package msx_audio_pkg;

   // Unsigned PSG mix level, three channels of up to 240 each
   typedef logic [9:0] psg_level_t;

   // PSG level plus key beep and cassette contributions
   typedef logic [10:0] mix_level_t;

   // Signed sum before the clamp
   typedef logic signed [16:0] mix_sum_t;

   // Final signed audio sample
   typedef logic signed [15:0] sample_t;

endpackage

// File: src/msx_io_decoder.sv
`timescale 1ns/1ns

`include "msx_io_params.svh"

module msx_io_decoder (
   input  logic                  clk21m,
   input  logic                  exwait_n,
   input  logic                  io_req_i,
   input  logic                  io_wr_i,
   input  msx_bus_pkg::io_addr_t io_addr_i,
   input  msx_bus_pkg::io_data_t io_wdata_i,
   output logic                  io_ack_o,
   output msx_bus_pkg::io_data_t io_rdata_o,
   output logic                  ppi_stb_o,
   output logic                  psg_stb_o,
   output msx_bus_pkg::io_ofs_t  dev_ofs_o,
   output logic                  dev_wr_o,
   output msx_bus_pkg::io_data_t dev_wdata_o,
   input  msx_bus_pkg::io_data_t ppi_rdata_i,
   input  msx_bus_pkg::io_data_t psg_rdata_i
);
   import msx_bus_pkg::*;

   localparam io_addr_t ppi_base = `MSX_PPI_BASE;
   localparam io_addr_t psg_base = `MSX_PSG_BASE;

   io_dev_t  dev_sel;
   io_dev_t  dev_q;
   io_data_t rd_mux;
   logic     busy_q;
   logic     start;

   // PPI owns all four ports, PSG only the first three
   always_comb begin
      dev_sel = DEV_NONE;
      if (io_addr_i[7:2] == ppi_base[7:2]) begin
         dev_sel = DEV_PPI;
      end else if (io_addr_i[7:2] == psg_base[7:2] && io_addr_i[1:0] != 2'b11) begin
         dev_sel = DEV_PSG;
      end
   end

   // New request only from idle, never while ack is still up
   assign start = io_req_i & ~busy_q & ~io_ack_o;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         busy_q    <= 1'b0;
         io_ack_o  <= 1'b0;
         ppi_stb_o <= 1'b0;
         psg_stb_o <= 1'b0;
      end else begin
         ppi_stb_o <= start && (dev_sel == DEV_PPI);
         psg_stb_o <= start && (dev_sel == DEV_PSG);
         if (start) begin
            busy_q <= 1'b1;
         end else if (busy_q) begin
            // Device has taken the strobe, acknowledge now
            busy_q   <= 1'b0;
            io_ack_o <= 1'b1;
         end else if (io_ack_o && !io_req_i) begin
            io_ack_o <= 1'b0;
         end
      end
   end

   // Unmapped reads float high like an open Z80 bus
   always_comb begin
      case (dev_q)
         DEV_PPI: rd_mux = ppi_rdata_i;
         DEV_PSG: rd_mux = psg_rdata_i;
         default: rd_mux = 8'hFF;
      endcase
   end

   always_ff @(posedge clk21m) begin
      if (start) begin
         dev_q       <= dev_sel;
         dev_ofs_o   <= io_addr_i[1:0];
         dev_wr_o    <= io_wr_i;
         dev_wdata_o <= io_wdata_i;
      end
      // Capture read data in the strobe cycle
      if (busy_q && !dev_wr_o) begin
         io_rdata_o <= rd_mux;
      end
   end

endmodule

// File: src/msx_ppi.sv
`timescale 1ns/1ns

`include "msx_io_params.svh"

module msx_ppi (
   input  logic                             clk21m,
   input  logic                             exwait_n,
   input  logic                             stb_i,
   input  msx_bus_pkg::io_ofs_t             ofs_i,
   input  logic                             wr_i,
   input  msx_bus_pkg::io_data_t            wdata_i,
   output msx_bus_pkg::io_data_t            rdata_o,
   input  logic [`MSX_KB_ROWS*8-1:0]        kb_matrix_i,
   input  logic [15:0]                      mem_addr_i,
   output logic [1:0]                       slot_o,
   output logic                             keybeep_o,
   output logic                             cas_motor_o
);
   import msx_bus_pkg::*;

   localparam int kb_rows = `MSX_KB_ROWS;

   io_data_t   port_a_q;
   io_data_t   port_c_q;
   io_data_t   row_data;
   logic       map_valid_q;
   logic [3:0] row;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         port_a_q    <= 8'h00;
         port_c_q    <= 8'h00;
         map_valid_q <= 1'b0;
      end else if (stb_i && wr_i) begin
         case (ofs_i)
            2'd0: begin
               port_a_q    <= wdata_i;
               map_valid_q <= 1'b1;
            end
            2'd2: port_c_q <= wdata_i;
            2'd3: begin
               // Bit set/reset of port C, mode words are not supported
               if (!wdata_i[7]) begin
                  port_c_q[wdata_i[3:1]] <= wdata_i[0];
               end
            end
            // Port B is the keyboard input, writes are dropped
            default: ;
         endcase
      end
   end

   // Keyboard row selected by the low nibble of port C
   assign row = port_c_q[3:0];

   always_comb begin
      row_data = 8'hFF;
      for (int r = 0; r < kb_rows; r++) begin
         if (row == r) begin
            row_data = kb_matrix_i[r*8 +: 8];
         end
      end
   end

   always_comb begin
      case (ofs_i)
         2'd0:    rdata_o = port_a_q;
         2'd1:    rdata_o = row_data;
         2'd2:    rdata_o = port_c_q;
         default: rdata_o = 8'hFF;
      endcase
   end

   // Primary slot of the current 16K page
   always_comb begin
      if (!map_valid_q) begin
         slot_o = 2'b00;
      end else begin
         case (mem_addr_i[15:14])
            2'b00:   slot_o = port_a_q[1:0];
            2'b01:   slot_o = port_a_q[3:2];
            2'b10:   slot_o = port_a_q[5:4];
            default: slot_o = port_a_q[7:6];
         endcase
      end
   end

   assign keybeep_o   = port_c_q[7];
   assign cas_motor_o = port_c_q[4];

endmodule

// File: src/msx_psg.sv
`timescale 1ns/1ns

`include "msx_io_params.svh"

module msx_psg (
   input  logic                      clk21m,
   input  logic                      exwait_n,
   input  logic                      ce_3m58_i,
   input  logic                      stb_i,
   input  msx_bus_pkg::io_ofs_t      ofs_i,
   input  logic                      wr_i,
   input  msx_bus_pkg::io_data_t     wdata_i,
   output msx_bus_pkg::io_data_t     rdata_o,
   output msx_audio_pkg::psg_level_t level_o
);
   import msx_bus_pkg::*;
   import msx_audio_pkg::*;

   localparam int tone_w = `MSX_TONE_W;

   logic [3:0]        idx_q;
   io_data_t          regs_q [16];
   logic [15:0]       raw_period [3];
   logic [tone_w-1:0] limit [3];
   logic [tone_w-1:0] cnt_q [3];
   logic [2:0]        tone_q;
   logic [2:0]        chan_on;
   psg_level_t        chan_lvl [3];

   // Address latch on A0, data write on A1
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         idx_q <= 4'd0;
         for (int i = 0; i < 16; i++) begin
            regs_q[i] <= 8'h00;
         end
      end else if (stb_i && wr_i) begin
         if (ofs_i == 2'd0) begin
            idx_q <= wdata_i[3:0];
         end else if (ofs_i == 2'd1) begin
            regs_q[idx_q] <= wdata_i;
         end
      end
   end

   // Only A2 has read data
   assign rdata_o = (ofs_i == 2'd2) ? regs_q[idx_q] : 8'hFF;

   for (genvar ch = 0; ch < 3; ch++) begin : g_tone
      // Fine and coarse tune registers of the channel
      assign raw_period[ch] = {regs_q[2*ch+1], regs_q[2*ch]};

      // A zero period behaves as one
      assign limit[ch] = (raw_period[ch][tone_w-1:0] == '0) ?
                         tone_w'(1) : raw_period[ch][tone_w-1:0];

      always_ff @(posedge clk21m or negedge exwait_n) begin
         if (!exwait_n) begin
            cnt_q[ch]  <= '0;
            tone_q[ch] <= 1'b1;
         end else if (ce_3m58_i) begin
            if (cnt_q[ch] >= limit[ch] - 1'b1) begin
               cnt_q[ch]  <= '0;
               tone_q[ch] <= ~tone_q[ch];
            end else begin
               cnt_q[ch] <= cnt_q[ch] + 1'b1;
            end
         end
      end

      // Mixer register bit set means the tone is off and the output stays high
      assign chan_on[ch] = tone_q[ch] | regs_q[7][ch];

      // Volume times 16 while high
      assign chan_lvl[ch] = chan_on[ch] ? psg_level_t'({regs_q[8+ch][3:0], 4'b0000}) :
                                          psg_level_t'(0);
   end

   assign level_o = chan_lvl[0] + chan_lvl[1] + chan_lvl[2];

endmodule

// File: src/msx_audio_mix.sv
`timescale 1ns/1ns

module msx_audio_mix (
   input  logic                      clk21m,
   input  logic                      exwait_n,
   input  msx_audio_pkg::psg_level_t psg_level_i,
   input  logic                      keybeep_i,
   input  logic                      cas_motor_i,
   input  logic                      cas_audio_i,
   input  msx_audio_pkg::sample_t    cart_sound_i,
   output msx_audio_pkg::sample_t    audio_o
);
   import msx_audio_pkg::*;

   mix_level_t lvl_sum;
   mix_sum_t   mix;
   sample_t    clamp;

   // Cassette input is only heard while the motor is off
   assign lvl_sum = {1'b0, psg_level_i}
                  + (keybeep_i ? 11'd512 : 11'd0)
                  + ((cas_audio_i && !cas_motor_i) ? 11'd256 : 11'd0);

   // Level scaled by 16 plus the sign-extended cartridge sample
   assign mix = {2'b00, lvl_sum, 4'b0000} + {cart_sound_i[15], cart_sound_i};

   always_comb begin
      if (mix > 17'sd32767) begin
         clamp = 16'sh7FFF;
      end else if (mix < -17'sd32768) begin
         clamp = 16'sh8000;
      end else begin
         clamp = mix[15:0];
      end
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         audio_o <= '0;
      end else begin
         audio_o <= clamp;
      end
   end

endmodule

// File: src/msx_io_top.sv
`timescale 1ns/1ns

`include "msx_io_params.svh"

module msx_io_top (
   input  logic                      clk21m,
   input  logic                      exwait_n,
   input  logic                      ce_3m58_i,
   input  logic                      io_req_i,
   input  logic                      io_wr_i,
   input  msx_bus_pkg::io_addr_t     io_addr_i,
   input  msx_bus_pkg::io_data_t     io_wdata_i,
   output logic                      io_ack_o,
   output msx_bus_pkg::io_data_t     io_rdata_o,
   input  logic [15:0]               mem_addr_i,
   input  logic [`MSX_KB_ROWS*8-1:0] kb_matrix_i,
   input  logic                      cas_audio_i,
   input  msx_audio_pkg::sample_t    cart_sound_i,
   output logic [1:0]                slot_o,
   output logic                      cas_motor_o,
   output msx_audio_pkg::sample_t    audio_o
);
   import msx_bus_pkg::*;
   import msx_audio_pkg::*;

   logic       ppi_stb;
   logic       psg_stb;
   logic       dev_wr;
   logic       keybeep;
   io_ofs_t    dev_ofs;
   io_data_t   dev_wdata;
   io_data_t   ppi_rdata;
   io_data_t   psg_rdata;
   psg_level_t psg_level;

   msx_io_decoder u_decoder (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .io_req_i    (io_req_i),
      .io_wr_i     (io_wr_i),
      .io_addr_i   (io_addr_i),
      .io_wdata_i  (io_wdata_i),
      .io_ack_o    (io_ack_o),
      .io_rdata_o  (io_rdata_o),
      .ppi_stb_o   (ppi_stb),
      .psg_stb_o   (psg_stb),
      .dev_ofs_o   (dev_ofs),
      .dev_wr_o    (dev_wr),
      .dev_wdata_o (dev_wdata),
      .ppi_rdata_i (ppi_rdata),
      .psg_rdata_i (psg_rdata)
   );

   msx_ppi u_ppi (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .stb_i       (ppi_stb),
      .ofs_i       (dev_ofs),
      .wr_i        (dev_wr),
      .wdata_i     (dev_wdata),
      .rdata_o     (ppi_rdata),
      .kb_matrix_i (kb_matrix_i),
      .mem_addr_i  (mem_addr_i),
      .slot_o      (slot_o),
      .keybeep_o   (keybeep),
      .cas_motor_o (cas_motor_o)
   );

   msx_psg u_psg (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .ce_3m58_i (ce_3m58_i),
      .stb_i     (psg_stb),
      .ofs_i     (dev_ofs),
      .wr_i      (dev_wr),
      .wdata_i   (dev_wdata),
      .rdata_o   (psg_rdata),
      .level_o   (psg_level)
   );

   msx_audio_mix u_mix (
      .clk21m       (clk21m),
      .exwait_n     (exwait_n),
      .psg_level_i  (psg_level),
      .keybeep_i    (keybeep),
      .cas_motor_i  (cas_motor_o),
      .cas_audio_i  (cas_audio_i),
      .cart_sound_i (cart_sound_i),
      .audio_o      (audio_o)
   );

endmodule

// File: verif/msx_io_asserts.sv
`timescale 1ns/1ns

`include "msx_io_params.svh"

module msx_io_asserts (
   input logic                  clk21m,
   input logic                  exwait_n,
   input logic                  io_req_i,
   input msx_bus_pkg::io_addr_t io_addr_i,
   input logic                  io_ack_o,
   input logic                  ppi_stb_o,
   input logic                  psg_stb_o,
   input msx_bus_pkg::io_dev_t  dev_q
);
   import msx_bus_pkg::*;

   localparam io_addr_t ppi_base = `MSX_PPI_BASE;
   localparam io_addr_t psg_base = `MSX_PSG_BASE;

   int unsigned fail_count = 0;
   io_dev_t     port_dev;

   // Owner of the port on the bus, four PPI ports and three PSG ports
   always_comb begin
      port_dev = DEV_NONE;
      if (io_addr_i >= ppi_base && io_addr_i <= ppi_base + 8'd3) begin
         port_dev = DEV_PPI;
      end else if (io_addr_i >= psg_base && io_addr_i <= psg_base + 8'd2) begin
         port_dev = DEV_PSG;
      end
   end

   // Ack answers a request that was already up the cycle before
   ack_needs_req: assert property (@(posedge clk21m) disable iff (!exwait_n)
      $rose(io_ack_o) |-> $past(io_req_i))
      else begin
         fail_count++;
         $error("io_ack_o rose without a pending io_req_i");
      end

   // One device per request, and it owns the port that was on the bus
   one_strobe: assert property (@(posedge clk21m) disable iff (!exwait_n)
      $onehot0({ppi_stb_o, psg_stb_o}) &&
      (!ppi_stb_o || $past(port_dev) == DEV_PPI) &&
      (!psg_stb_o || $past(port_dev) == DEV_PSG))
      else begin
         fail_count++;
         $error("strobe error, ppi %b psg %b dev %s", ppi_stb_o, psg_stb_o, dev_q.name());
      end

   ack_low_in_reset: assert property (@(posedge clk21m) !exwait_n |-> !io_ack_o)
      else begin
         fail_count++;
         $error("io_ack_o high while exwait_n is low");
      end

endmodule

bind msx_io_decoder msx_io_asserts u_asserts (
   .clk21m    (clk21m),
   .exwait_n  (exwait_n),
   .io_req_i  (io_req_i),
   .io_addr_i (io_addr_i),
   .io_ack_o  (io_ack_o),
   .ppi_stb_o (ppi_stb_o),
   .psg_stb_o (psg_stb_o),
   .dev_q     (dev_q)
);

// File: verif/msx_io_tb.sv
`timescale 1ns/1ns

`include "msx_io_params.svh"

module msx_io_tb;
   import msx_audio_pkg::*;

   typedef enum logic [1:0] {OP_WR, OP_RD, OP_SET} op_t;
   typedef enum logic [2:0] {CHK_NONE, CHK_RDATA, CHK_SLOT, CHK_MOTOR, CHK_AUDIO} chk_t;

   // For OP_SET the data field is the cartridge sample
   typedef struct {
      int          test;
      op_t         op;
      logic [7:0]  port;
      logic [15:0] data;
      logic [15:0] mem_addr;
      logic        cas;
      logic [15:0] exp;
      chk_t        chk;
   } step_t;

   logic                      clk21m = 1'b0;
   logic                      exwait_n;
   logic                      ce_3m58_i;
   logic                      io_req_i;
   logic                      io_wr_i;
   logic [7:0]                io_addr_i;
   logic [7:0]                io_wdata_i;
   logic                      io_ack_o;
   logic [7:0]                io_rdata_o;
   logic [15:0]               mem_addr_i;
   logic [`MSX_KB_ROWS*8-1:0] kb_matrix_i;
   logic                      cas_audio_i;
   sample_t                   cart_sound_i;
   logic [1:0]                slot_o;
   logic                      cas_motor_o;
   sample_t                   audio_o;

   // Reference state of the I/O side, updated as the table is built
   step_t       steps [$];
   int          cur_test;
   logic [15:0] cur_mem;
   logic [15:0] cur_cart;
   logic        cur_cas;
   logic [7:0]  m_pa;
   logic [7:0]  m_pc;
   logic [7:0]  m_regs [16];
   logic [3:0]  m_idx;
   logic        m_mapped;
   int          checks;
   int          errors;
   int          t_checks;
   int          t_errors;
   bit          hung;

   msx_io_top uut (.*);

   always #50 clk21m = ~clk21m;

   task automatic add_step(op_t op, logic [7:0] port, logic [15:0] data, logic [15:0] exp,
                           chk_t chk);
      steps.push_back('{cur_test, op, port, data, cur_mem, cur_cas, exp, chk});
   endtask

   task automatic write_step(logic [7:0] port, logic [7:0] d);
      add_step(OP_WR, port, {8'h00, d}, 16'h0000, CHK_NONE);
      case (port)
         8'hA8: begin
            m_pa     = d;
            m_mapped = 1'b1;
         end
         8'hAA: m_pc = d;
         8'hAB: if (!d[7]) m_pc[d[3:1]] = d[0];
         8'hA0: m_idx = d[3:0];
         8'hA1: m_regs[m_idx] = d;
         default: ;
      endcase
   endtask

   task automatic read_step(logic [7:0] port);
      logic [7:0] exp;
      case (port)
         8'hA8: exp = m_pa;
         8'hA9: exp = (m_pc[3:0] < `MSX_KB_ROWS) ? kb_matrix_i[m_pc[3:0]*8 +: 8] : 8'hFF;
         8'hAA: exp = m_pc;
         8'hA2: exp = m_regs[m_idx];
         default: exp = 8'hFF;
      endcase
      add_step(OP_RD, port, 16'h0000, {8'h00, exp}, CHK_RDATA);
   endtask

   task automatic psg_write(logic [3:0] r, logic [7:0] d);
      write_step(8'hA0, {4'h0, r});
      write_step(8'hA1, d);
   endtask

   task automatic slot_check(logic [15:0] mem);
      logic [1:0] exp;
      cur_mem = mem;
      exp = m_mapped ? m_pa[mem[15:14]*2 +: 2] : 2'b00;
      add_step(OP_SET, 8'h00, cur_cart, {14'd0, exp}, CHK_SLOT);
   endtask

   task automatic motor_check();
      add_step(OP_SET, 8'h00, cur_cart, {15'd0, m_pc[4]}, CHK_MOTOR);
   endtask

   task automatic audio_check(logic [15:0] cart, logic cas);
      int      level;
      int      total;
      shortint cart_s;
      cur_cart = cart;
      cur_cas  = cas;
      cart_s   = cart;
      // Audio is only checked with tones off or silent, so every channel counts as high
      level = 16 * (m_regs[8][3:0] + m_regs[9][3:0] + m_regs[10][3:0]);
      if (m_pc[7]) level += 512;
      if (cas && !m_pc[4]) level += 256;
      total = level * 16 + cart_s;
      if (total > 32767) total = 32767;
      if (total < -32768) total = -32768;
      add_step(OP_SET, 8'h00, cart, total[15:0], CHK_AUDIO);
   endtask

   task automatic build_table();
      int rows [8] = '{0, 3, 7, 10, 11, 12, 15, 5};
      m_pa     = 8'h00;
      m_pc     = 8'h00;
      m_idx    = 4'h0;
      m_mapped = 1'b0;
      cur_mem  = 16'h0000;
      cur_cart = 16'h0000;
      cur_cas  = 1'b0;
      foreach (m_regs[r]) m_regs[r] = 8'h00;
      cur_test = 1;
      for (int k = 0; k < 4; k++) slot_check({2'(k), 14'($urandom)});
      audio_check(16'h0000, 1'b0);
      motor_check();
      cur_test = 2;
      for (int n = 0; n < 2; n++) begin
         write_step(8'hA8, 8'($urandom));
         for (int k = 0; k < 4; k++) slot_check({2'(k), 14'($urandom)});
         read_step(8'hA8);
      end
      cur_test = 3;
      foreach (rows[j]) begin
         write_step(8'hAA, {4'($urandom), 4'(rows[j])});
         read_step(8'hA9);
         read_step(8'hAA);
         motor_check();
      end
      // Bit 7 set is a mode word and must leave port C alone
      write_step(8'hAB, 8'h09);
      motor_check();
      write_step(8'hAB, 8'h88);
      motor_check();
      write_step(8'hAB, 8'h08);
      motor_check();
      write_step(8'hAB, 8'h01);
      read_step(8'hA9);
      cur_test = 4;
      for (int r = 0; r < 16; r++) psg_write(4'(r), 8'($urandom));
      for (int r = 0; r < 16; r++) begin
         write_step(8'hA0, 8'(r));
         read_step(8'hA2);
      end
      write_step(8'h50, 8'($urandom));
      read_step(8'hA3);
      read_step(8'h00);
      read_step(8'h9F);
      read_step(8'hFF);
      read_step(8'hAB);
      read_step(8'hA2);
      cur_test = 5;
      psg_write(4'd7, 8'h3F);
      write_step(8'hAB, 8'h0E);
      write_step(8'hAB, 8'h08);
      for (int c = 8; c < 11; c++) psg_write(4'(c), 8'h00);
      audio_check(16'($urandom), 1'b0);
      audio_check(16'h8000, 1'b0);
      audio_check(16'($urandom), 1'b1);
      for (int c = 8; c < 11; c++) psg_write(4'(c), 8'h0F);
      audio_check(16'($urandom), 1'b1);
      write_step(8'hAB, 8'h0F);
      audio_check(16'h7FFF, 1'b1);
      audio_check(16'h8000, 1'b1);
      write_step(8'hAB, 8'h09);
      audio_check(16'($urandom), 1'b1);
      for (int n = 0; n < 4; n++) begin
         for (int c = 8; c < 11; c++) psg_write(4'(c), 8'($urandom));
         write_step(8'hAB, {7'b0000111, 1'($urandom)});
         audio_check(16'($urandom), 1'($urandom));
      end
   endtask

   // Four-phase transfer, entered and left 5 ns after a rising edge
   task automatic bus_xfer(logic wr, logic [7:0] port, logic [7:0] d, output logic [7:0] rd,
                           output bit ok);
      int n;
      io_req_i   = 1'b1;
      io_wr_i    = wr;
      io_addr_i  = port;
      io_wdata_i = d;
      n = 0;
      while (io_ack_o !== 1'b1 && n < 100) begin
         @(posedge clk21m);
         #5;
         n++;
      end
      rd       = io_rdata_o;
      io_req_i = 1'b0;
      ok       = (io_ack_o === 1'b1);
      if (!ok) begin
         $display("timeout: io_ack_o did not rise for port %h", port);
         return;
      end
      n = 0;
      while (io_ack_o !== 1'b0 && n < 100) begin
         @(posedge clk21m);
         #5;
         n++;
      end
      ok = (io_ack_o === 1'b0);
      if (!ok) $display("timeout: io_ack_o did not fall for port %h", port);
   endtask

   task automatic apply_step(step_t s);
      logic [7:0]  rd;
      logic [15:0] got;
      bit          ok;
      string       name;
      ok  = 1'b1;
      rd  = 8'h00;
      got = 16'h0000;
      if (s.op == OP_SET) begin
         mem_addr_i   = s.mem_addr;
         cart_sound_i = s.data;
         cas_audio_i  = s.cas;
         // Registered audio needs two edges to show the new inputs
         repeat (2) begin
            @(posedge clk21m);
            #5;
         end
      end else begin
         bus_xfer(s.op == OP_WR, s.port, s.data[7:0], rd, ok);
      end
      if (!ok) begin
         hung = 1'b1;
         errors++;
         t_errors++;
         return;
      end
      case (s.chk)
         CHK_RDATA: begin
            got  = {8'h00, rd};
            name = "io_rdata_o";
         end
         CHK_SLOT: begin
            got  = {14'd0, slot_o};
            name = "slot_o";
         end
         CHK_MOTOR: begin
            got  = {15'd0, cas_motor_o};
            name = "cas_motor_o";
         end
         default: begin
            got  = audio_o;
            name = "audio_o";
         end
      endcase
      if (s.chk != CHK_NONE) begin
         checks++;
         t_checks++;
         if (got !== s.exp) begin
            errors++;
            t_errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, s.exp);
         end
      end
   endtask

   initial begin
      void'($urandom(32'h83a4f760));
      exwait_n     = 1'b0;
      ce_3m58_i    = 1'b1;
      io_req_i     = 1'b0;
      io_wr_i      = 1'b0;
      io_addr_i    = 8'h00;
      io_wdata_i   = 8'h00;
      mem_addr_i   = 16'h0000;
      cas_audio_i  = 1'b0;
      cart_sound_i = 16'sh0000;
      for (int r = 0; r < `MSX_KB_ROWS; r++) begin
         kb_matrix_i[r*8 +: 8] = 8'($urandom);
      end
      checks   = 0;
      errors   = 0;
      t_checks = 0;
      t_errors = 0;
      hung     = 1'b0;
      build_table();
      repeat (5) @(posedge clk21m);
      #5;
      exwait_n = 1'b1;
      for (int i = 0; i < steps.size() && !hung; i++) begin
         apply_step(steps[i]);
         if (hung || i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
            $display("test %0d: %0d checks, %0d errors", steps[i].test, t_checks, t_errors);
            t_checks = 0;
            t_errors = 0;
         end
      end
      $display("total: %0d checks, %0d errors, %0d assertion failures", checks, errors,
               uut.u_decoder.u_asserts.fail_count);
      if (errors == 0 && uut.u_decoder.u_asserts.fail_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: sources.f
+incdir+src
src/msx_bus_pkg.sv
src/msx_audio_pkg.sv
src/msx_io_decoder.sv
src/msx_ppi.sv
src/msx_psg.sv
src/msx_audio_mix.sv
src/msx_io_top.sv
verif/msx_io_asserts.sv
verif/msx_io_tb.sv
